//--- Makefile
SIM       = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_game_control
FILE_LIST = all.f

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- all.f
+incdir+testbench
hdl/game_pkg.sv
hdl/button_mapper.sv
hdl/phase_sequencer.sv
hdl/countdown_timer.sv
hdl/maze_port_arbiter.sv
hdl/maze_memory.sv
hdl/game_control_top.sv
testbench/tb_game_control.sv

//--- hdl/button_mapper.sv
module button_mapper (
    input  logic                             basys_clock,
    input  logic                             reset_edge_effective,
    input  logic [game_pkg::NUM_BUTTONS-1:0] pb,
    input  logic                             move_mode,
    output logic                             gen_edge,
    output logic                             next_level_edge,
    output logic [game_pkg::NUM_BUTTONS-1:0] move_edges
);
    import game_pkg::*;

    logic [NUM_BUTTONS-1:0] pb_prev;
    logic [NUM_BUTTONS-1:0] pb_rise;

    // High in the first sampled cycle of a press
    assign pb_rise = pb & ~pb_prev;

    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            pb_prev <= '0;
        end else begin
            pb_prev <= pb;
        end
    end

    // Setup actions, only with the mode switch low
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            gen_edge        <= 1'b0;
            next_level_edge <= 1'b0;
        end else begin
            gen_edge        <= pb_rise[BTN_UP] & ~move_mode;
            next_level_edge <= pb_rise[BTN_DOWN] & ~move_mode;
        end
    end

    // Move actions keep the button order: stop, up, left, right, down
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            move_edges <= '0;
        end else if (move_mode) begin
            move_edges <= pb_rise;
        end else begin
            move_edges <= '0;
        end
    end

endmodule

//--- hdl/countdown_timer.sv
module countdown_timer #(
    parameter int TICK_CYCLES = 100_000_000
) (
    input  logic                                basys_clock,
    input  logic                                reset_edge_effective,
    input  game_pkg::game_phase_t               phase,
    input  logic [game_pkg::TIME_SETTING_W-1:0] time_setting,
    output logic [game_pkg::TIME_W-1:0]         time_left,
    output logic                                game_done
);
    import game_pkg::*;

    logic [$clog2(TICK_CYCLES)-1:0] tick_count;
    logic [TIME_W-1:0]              time_limit;
    logic [TIME_W-1:0]              seconds;
    logic                           in_play;
    logic                           tick;

    assign in_play = (phase == DISPLAY_MAZE);
    assign tick    = in_play && (32'(tick_count) == TICK_CYCLES - 1);

    // Limit for the selected time setting
    always_comb begin
        case (time_setting)
            TIME_SETTING_W'(1): time_limit = TIME_LIMIT_1;
            TIME_SETTING_W'(2): time_limit = TIME_LIMIT_2;
            TIME_SETTING_W'(3): time_limit = TIME_LIMIT_3;
            TIME_SETTING_W'(4): time_limit = TIME_LIMIT_4;
            default:            time_limit = TIME_LIMIT_DEFAULT;
        endcase
    end

    // One-second divider, parked at zero outside play
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            tick_count <= '0;
        end else if (!in_play || tick) begin
            tick_count <= '0;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    // Seconds counter reloads every cycle until play starts
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            seconds   <= TIME_LIMIT_DEFAULT;
            game_done <= 1'b0;
        end else if (!in_play) begin
            seconds <= time_limit;
        end else if (tick) begin
            if (seconds != '0) begin
                seconds <= seconds - 1'b1;
            end else begin
                game_done <= 1'b1;
            end
        end
    end

    // Outside play the display follows the switch setting directly
    assign time_left = in_play ? seconds : time_limit;

endmodule

//--- hdl/game_control_top.sv
module game_control_top #(
    parameter int TICK_CYCLES = 100_000_000
) (
    input  logic                                basys_clock,
    input  logic                                reset_edge_effective,
    input  logic [game_pkg::NUM_BUTTONS-1:0]    pb,
    input  logic                                move_mode,
    input  logic [game_pkg::TIME_SETTING_W-1:0] time_setting,
    input  logic                                gen_done,
    input  logic                                placement_done,
    input  logic                                spawn_done,
    input  logic [game_pkg::CELL_ADDR_W-1:0]    gen_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]    place_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]    spawn_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]    move_rd_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]    move_wr_addr,
    input  logic [game_pkg::CELL_DATA_W-1:0]    gen_data,
    input  logic [game_pkg::CELL_DATA_W-1:0]    place_data,
    input  logic [game_pkg::CELL_DATA_W-1:0]    move_data,
    input  logic                                gen_we,
    input  logic                                place_we,
    input  logic                                move_we,
    output game_pkg::game_phase_t               phase,
    output logic [game_pkg::LEVEL_W-1:0]        level_select,
    output logic                                collectibles_restart,
    output logic [game_pkg::NUM_BUTTONS-1:0]    move_edges,
    output logic [game_pkg::TIME_W-1:0]         time_left,
    output logic                                game_done,
    output logic [game_pkg::CELL_DATA_W-1:0]    cell_rd_data
);
    import game_pkg::*;

    logic                   gen_edge;
    logic                   next_level_edge;
    logic                   mem_en;
    logic                   mem_we;
    logic [CELL_ADDR_W-1:0] mem_addr;
    logic [CELL_DATA_W-1:0] mem_wr_data;

    button_mapper button_mapper_inst (
        .basys_clock          (basys_clock),
        .reset_edge_effective (reset_edge_effective),
        .pb                   (pb),
        .move_mode            (move_mode),
        .gen_edge             (gen_edge),
        .next_level_edge      (next_level_edge),
        .move_edges           (move_edges)
    );

    phase_sequencer phase_sequencer_inst (
        .basys_clock          (basys_clock),
        .reset_edge_effective (reset_edge_effective),
        .gen_edge             (gen_edge),
        .next_level_edge      (next_level_edge),
        .gen_done             (gen_done),
        .placement_done       (placement_done),
        .spawn_done           (spawn_done),
        .phase                (phase),
        .level_select         (level_select),
        .collectibles_restart (collectibles_restart)
    );

    countdown_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) countdown_timer_inst (
        .basys_clock          (basys_clock),
        .reset_edge_effective (reset_edge_effective),
        .phase                (phase),
        .time_setting         (time_setting),
        .time_left            (time_left),
        .game_done            (game_done)
    );

    // Engines share the single maze port by phase
    maze_port_arbiter maze_port_arbiter_inst (
        .phase        (phase),
        .gen_addr     (gen_addr),
        .gen_data     (gen_data),
        .gen_we       (gen_we),
        .place_addr   (place_addr),
        .place_data   (place_data),
        .place_we     (place_we),
        .spawn_addr   (spawn_addr),
        .move_rd_addr (move_rd_addr),
        .move_wr_addr (move_wr_addr),
        .move_data    (move_data),
        .move_we      (move_we),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data)
    );

    maze_memory maze_memory_inst (
        .basys_clock  (basys_clock),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wr_data  (mem_wr_data),
        .cell_rd_data (cell_rd_data)
    );

endmodule

//--- hdl/game_pkg.sv
package game_pkg;

    // Game phases, in the order the sequencer walks them
    typedef enum logic [2:0] {
        IDLE               = 3'd0,
        INIT_MAZE          = 3'd1,
        PLACE_COLLECTIBLES = 3'd2,
        PLACE_PLAYER       = 3'd3,
        DISPLAY_MAZE       = 3'd4
    } game_phase_t;

    // Maze store, 16 by 16 cells
    localparam int CELL_ADDR_W = 8;
    localparam int CELL_DATA_W = 9;
    localparam int MAZE_CELLS  = 256;

    // Countdown in seconds
    localparam int TIME_W         = 8;
    localparam int TIME_SETTING_W = 3;

    localparam logic [TIME_W-1:0] TIME_LIMIT_1       = 8'd60;
    localparam logic [TIME_W-1:0] TIME_LIMIT_2       = 8'd120;
    localparam logic [TIME_W-1:0] TIME_LIMIT_3       = 8'd180;
    localparam logic [TIME_W-1:0] TIME_LIMIT_4       = 8'd240;
    localparam logic [TIME_W-1:0] TIME_LIMIT_DEFAULT = 8'd180;

    // Level range
    localparam int LEVEL_W = 3;
    localparam logic [LEVEL_W-1:0] LEVEL_FIRST = 3'd1;
    localparam logic [LEVEL_W-1:0] LEVEL_LAST  = 3'd6;

    // Push buttons and their bit positions in pb
    localparam int NUM_BUTTONS = 5;
    localparam int BTN_CENTER  = 0;
    localparam int BTN_UP      = 1;
    localparam int BTN_LEFT    = 2;
    localparam int BTN_RIGHT   = 3;
    localparam int BTN_DOWN    = 4;

endpackage

//--- hdl/maze_memory.sv
module maze_memory (
    input  logic                             basys_clock,
    input  logic                             mem_en,
    input  logic                             mem_we,
    input  logic [game_pkg::CELL_ADDR_W-1:0] mem_addr,
    input  logic [game_pkg::CELL_DATA_W-1:0] mem_wr_data,
    output logic [game_pkg::CELL_DATA_W-1:0] cell_rd_data
);
    import game_pkg::*;

    logic [CELL_DATA_W-1:0] cells [MAZE_CELLS];

    // Write-first, so a written cell is seen on the next cycle
    always_ff @(posedge basys_clock) begin
        if (mem_en) begin
            if (mem_we) begin
                cells[mem_addr] <= mem_wr_data;
                cell_rd_data    <= mem_wr_data;
            end else begin
                cell_rd_data <= cells[mem_addr];
            end
        end
    end

endmodule

//--- hdl/maze_port_arbiter.sv
module maze_port_arbiter (
    input  game_pkg::game_phase_t             phase,
    input  logic [game_pkg::CELL_ADDR_W-1:0]  gen_addr,
    input  logic [game_pkg::CELL_DATA_W-1:0]  gen_data,
    input  logic                              gen_we,
    input  logic [game_pkg::CELL_ADDR_W-1:0]  place_addr,
    input  logic [game_pkg::CELL_DATA_W-1:0]  place_data,
    input  logic                              place_we,
    input  logic [game_pkg::CELL_ADDR_W-1:0]  spawn_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]  move_rd_addr,
    input  logic [game_pkg::CELL_ADDR_W-1:0]  move_wr_addr,
    input  logic [game_pkg::CELL_DATA_W-1:0]  move_data,
    input  logic                              move_we,
    output logic                              mem_en,
    output logic                              mem_we,
    output logic [game_pkg::CELL_ADDR_W-1:0]  mem_addr,
    output logic [game_pkg::CELL_DATA_W-1:0]  mem_wr_data
);
    import game_pkg::*;

    always_comb begin
        mem_en      = 1'b0;
        mem_we      = 1'b0;
        mem_addr    = '0;
        mem_wr_data = '0;
        case (phase)
            INIT_MAZE: begin
                mem_en      = 1'b1;
                mem_we      = gen_we;
                mem_addr    = gen_addr;
                mem_wr_data = gen_data;
            end
            PLACE_COLLECTIBLES: begin
                mem_en      = 1'b1;
                mem_we      = place_we;
                mem_addr    = place_addr;
                mem_wr_data = place_data;
            end
            PLACE_PLAYER: begin
                // Spawner only looks for an open cell
                mem_en   = 1'b1;
                mem_addr = spawn_addr;
            end
            DISPLAY_MAZE: begin
                mem_en = 1'b1;
                if (move_we) begin
                    mem_we      = 1'b1;
                    mem_addr    = move_wr_addr;
                    mem_wr_data = move_data;
                end else begin
                    mem_addr = move_rd_addr;
                end
            end
            default: begin
                mem_en = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/phase_sequencer.sv
module phase_sequencer (
    input  logic                         basys_clock,
    input  logic                         reset_edge_effective,
    input  logic                         gen_edge,
    input  logic                         next_level_edge,
    input  logic                         gen_done,
    input  logic                         placement_done,
    input  logic                         spawn_done,
    output game_pkg::game_phase_t        phase,
    output logic [game_pkg::LEVEL_W-1:0] level_select,
    output logic                         collectibles_restart
);
    import game_pkg::*;

    game_phase_t next_phase;

    // Next phase
    always_comb begin
        next_phase = phase;
        case (phase)
            IDLE: begin
                if (gen_edge) begin
                    next_phase = INIT_MAZE;
                end
            end
            INIT_MAZE: begin
                if (gen_done) begin
                    next_phase = PLACE_COLLECTIBLES;
                end
            end
            PLACE_COLLECTIBLES: begin
                if (placement_done) begin
                    next_phase = PLACE_PLAYER;
                end
            end
            PLACE_PLAYER: begin
                if (spawn_done) begin
                    next_phase = DISPLAY_MAZE;
                end
            end
            DISPLAY_MAZE: begin
                // A new maze is generated for the same or next level
                if (gen_edge) begin
                    next_phase = INIT_MAZE;
                end
            end
            default: begin
                next_phase = IDLE;
            end
        endcase
    end

    // Phase register and the restart pulse registered alongside it
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            phase                <= IDLE;
            collectibles_restart <= 1'b0;
        end else begin
            phase                <= next_phase;
            collectibles_restart <= (next_phase == PLACE_COLLECTIBLES) &&
                                    (phase != PLACE_COLLECTIBLES);
        end
    end

    // Level steps on every next-level press, in any phase
    always_ff @(posedge basys_clock or posedge reset_edge_effective) begin
        if (reset_edge_effective) begin
            level_select <= LEVEL_FIRST;
        end else if (next_level_edge) begin
            if (level_select >= LEVEL_LAST) begin
                level_select <= LEVEL_FIRST;
            end else begin
                level_select <= level_select + 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_game_control_table.svh
`ifndef TB_GAME_CONTROL_TABLE_SVH
`define TB_GAME_CONTROL_TABLE_SVH

    // Each row holds pb, mode, tset, done, we, addr, data and cycles, then the
    // expected phase, level, restart, move_edges and read data, then the check mask
    // pb value 2 presses up and 16 presses down
    // done bits from the top are gen_done, placement_done and spawn_done
    // we bits from the top are gen_we, place_we and move_we
    // Mask bit 0 checks phase, 1 level, 2 restart, 3 move_edges and 4 read data
    // Spawner and movement reads see addr inverted and movement writes see data inverted
    typedef struct packed {
        logic [NUM_BUTTONS-1:0]    pb;
        logic                      mode;
        logic [TIME_SETTING_W-1:0] tset;
        logic [2:0]                done;
        logic [2:0]                we;
        logic [CELL_ADDR_W-1:0]    addr;
        logic [CELL_DATA_W-1:0]    data;
        logic [7:0]                cycles;
        game_phase_t               exp_phase;
        logic [LEVEL_W-1:0]        exp_level;
        logic                      exp_restart;
        logic [NUM_BUTTONS-1:0]    exp_move;
        logic [CELL_DATA_W-1:0]    exp_rd;
        logic [4:0]                mask;
    } row_t;

    row_t rows [$];

    task automatic load_table();
        // Up press in setup mode gives the pulse first and the phase one edge later
        rows.push_back(row_t'{2, 0, 1, 0, 0, 0, 0, 1, IDLE, 1, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, INIT_MAZE, 1, 0, 0, 0, 'hf});
        // Generator writes land while the placer is shut out
        rows.push_back(row_t'{0, 0, 1, 0, 4, 'h11, 'ha5, 1, INIT_MAZE, 1, 0, 0, 'ha5, 'h11});
        rows.push_back(row_t'{0, 0, 1, 0, 4, 'h22, 'h15a, 1, INIT_MAZE, 1, 0, 0, 'h15a, 'h11});
        rows.push_back(row_t'{0, 0, 1, 0, 2, 'h11, 'h1ff, 1, INIT_MAZE, 1, 0, 0, 'ha5, 'h11});
        // Done strobes walk the phases with restart high for one cycle only
        rows.push_back(row_t'{0, 0, 1, 4, 0, 0, 0, 1, PLACE_COLLECTIBLES, 1, 1, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, PLACE_COLLECTIBLES, 1, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 2, 0, 0, 0, 1, PLACE_PLAYER, 1, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 'hee, 0, 1, PLACE_PLAYER, 1, 0, 0, 'ha5, 'h11});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 'hdd, 0, 1, PLACE_PLAYER, 1, 0, 0, 'h15a, 'h11});
        rows.push_back(row_t'{0, 0, 1, 1, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 0, 0, 'hf});
        // Movement write and its read back
        rows.push_back(row_t'{0, 0, 1, 0, 1, 'h33, 'h13c, 1, DISPLAY_MAZE, 1, 0, 0, 'hc3, 'h11});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 'hcc, 0, 1, DISPLAY_MAZE, 1, 0, 0, 'hc3, 'h11});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 'hee, 0, 1, DISPLAY_MAZE, 1, 0, 0, 'ha5, 'h11});
        // Up press in move mode
        rows.push_back(row_t'{2, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 2, 0, 'hf});
        rows.push_back(row_t'{0, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 0, 0, 'hf});
        // Stop then left then right in move mode
        rows.push_back(row_t'{1, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 1, 0, 'hf});
        rows.push_back(row_t'{4, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 4, 0, 'hf});
        rows.push_back(row_t'{8, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 8, 0, 'hf});
        rows.push_back(row_t'{0, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 0, 0, 'hf});
        // Seven down presses in setup mode
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 2, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 3, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 3, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 4, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 4, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 5, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 5, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 6, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 6, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 1, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 1, 0, 0, 0, 'hb});
        rows.push_back(row_t'{16, 0, 1, 0, 0, 0, 0, 2, DISPLAY_MAZE, 2, 0, 0, 0, 'hb});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 0, 0, 'hb});
        // Down press in move mode leaves the level alone
        rows.push_back(row_t'{16, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 16, 0, 'hb});
        rows.push_back(row_t'{0, 1, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 0, 0, 'hb});
        // New maze and back into play for the countdown
        rows.push_back(row_t'{2, 0, 1, 0, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 0, 0, 0, 0, 1, INIT_MAZE, 2, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 4, 0, 0, 0, 1, PLACE_COLLECTIBLES, 2, 1, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 2, 0, 0, 0, 1, PLACE_PLAYER, 2, 0, 0, 0, 'hf});
        rows.push_back(row_t'{0, 0, 1, 1, 0, 0, 0, 1, DISPLAY_MAZE, 2, 0, 0, 0, 'hf});
    endtask

`endif

//--- testbench/tb_game_control.sv
module tb_game_control;
    import game_pkg::*;

    localparam int TICK_CYCLES = 8;
    localparam int DRIVE_DELAY = 5;

    logic                      basys_clock = 1'b0;
    logic                      reset_edge_effective;
    logic [NUM_BUTTONS-1:0]    pb;
    logic                      move_mode;
    logic [TIME_SETTING_W-1:0] time_setting;
    logic                      gen_done;
    logic                      placement_done;
    logic                      spawn_done;
    logic                      gen_we;
    logic                      place_we;
    logic                      move_we;
    logic [CELL_ADDR_W-1:0]    cell_addr;
    logic [CELL_DATA_W-1:0]    cell_data;
    game_phase_t               phase;
    logic [LEVEL_W-1:0]        level_select;
    logic                      collectibles_restart;
    logic [NUM_BUTTONS-1:0]    move_edges;
    logic [TIME_W-1:0]         time_left;
    logic                      game_done;
    logic [CELL_DATA_W-1:0]    cell_rd_data;

    `include "tb_game_control_table.svh"

    always #20 basys_clock = ~basys_clock;

    // Read addresses and movement data reach the DUT inverted
    game_control_top #(
        .TICK_CYCLES (TICK_CYCLES)
    ) game_control_top_inst (
        .gen_addr     (cell_addr),
        .place_addr   (cell_addr),
        .spawn_addr   (~cell_addr),
        .move_rd_addr (~cell_addr),
        .move_wr_addr (cell_addr),
        .gen_data     (cell_data),
        .place_data   (cell_data),
        .move_data    (~cell_data),
        .*
    );

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Waits the given number of edges and settles past the last one
    task automatic advance(input int cycles);
        repeat (cycles) @(posedge basys_clock);
        #DRIVE_DELAY;
    endtask

    task automatic drive_row(input row_t r);
        pb             = r.pb;
        move_mode      = r.mode;
        time_setting   = r.tset;
        gen_done       = r.done[2];
        placement_done = r.done[1];
        spawn_done     = r.done[0];
        gen_we         = r.we[2];
        place_we       = r.we[1];
        move_we        = r.we[0];
        cell_addr      = r.addr;
        cell_data      = r.data;
    endtask

    task automatic apply_row(input row_t r);
        drive_row(r);
        advance(int'(r.cycles));
        if (r.mask[0]) check_value("phase", 32'(r.exp_phase), 32'(phase));
        if (r.mask[1]) check_value("level_select", 32'(r.exp_level), 32'(level_select));
        if (r.mask[2]) begin
            check_value("collectibles_restart", 32'(r.exp_restart),
                        32'(collectibles_restart));
        end
        if (r.mask[3]) check_value("move_edges", 32'(r.exp_move), 32'(move_edges));
        if (r.mask[4]) check_value("cell_rd_data", 32'(r.exp_rd), 32'(cell_rd_data));
    endtask

    task automatic wait_for_game_done(input int max_cycles, output int waited);
        waited = 0;
        while (game_done !== 1'b1) begin
            if (waited >= max_cycles) begin
                $display("timeout: game_done did not rise within %0d cycles", max_cycles);
                $display("TB FAILED");
                $fatal(1, "game_done wait timed out");
            end else begin
                advance(1);
                waited++;
            end
        end
    endtask

    initial begin
        int waited;
        reset_edge_effective = 1'b1;
        drive_row('0);
        load_table();
        repeat (4) @(posedge basys_clock);
        #DRIVE_DELAY;
        reset_edge_effective = 1'b0;

        // Reset state with time setting 0 selecting 180 s
        check_value("phase", 32'(IDLE), 32'(phase));
        check_value("level_select", 1, 32'(level_select));
        check_value("collectibles_restart", 0, 32'(collectibles_restart));
        check_value("move_edges", 0, 32'(move_edges));
        check_value("game_done", 0, 32'(game_done));
        check_value("time_left", 180, 32'(time_left));

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        // Play just started with the 60 s limit
        spawn_done = 1'b0;
        check_value("time_left", 60, 32'(time_left));
        for (int k = 1; k <= 60; k++) begin
            advance(TICK_CYCLES);
            check_value("time_left", 32'(60 - k), 32'(time_left));
            check_value("game_done", 0, 32'(game_done));
        end
        advance(TICK_CYCLES - 1);
        check_value("game_done", 0, 32'(game_done));
        wait_for_game_done(4, waited);
        check_value("game_done_delay", 1, 32'(waited));

        // Leaving play reloads the limit while game over stays set
        pb[BTN_UP] = 1'b1;
        advance(1);
        pb[BTN_UP] = 1'b0;
        advance(1);
        check_value("phase", 32'(INIT_MAZE), 32'(phase));
        check_value("time_left", 60, 32'(time_left));
        check_value("game_done", 1, 32'(game_done));

        $display("TB PASSED");
        $finish;
    end

endmodule
